// File: sb_pkg.sv
package sb_pkg;

    localparam int NUM_FU = 4;

    typedef logic [4:0] reg_idx_t;
    typedef logic [$clog2(NUM_FU)-1:0] fu_idx_t;

    typedef enum logic [2:0] {
        FU_NONE = 3'd0,
        FU_ALU  = 3'd1,
        FU_MEM  = 3'd2,
        FU_MUL  = 3'd3,
        FU_DIV  = 3'd4
    } fu_e;

    // Index 0 wins arbitration.
    localparam fu_e FU_OF_IDX [NUM_FU] = '{FU_ALU, FU_MEM, FU_MUL, FU_DIV};

    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [5:0] {
        OP_NONE,
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
        OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU,
        OP_ADDI, OP_ANDI, OP_ORI, OP_XORI,
        OP_SLLI, OP_SRLI, OP_SRAI, OP_SLTI, OP_SLTIU,
        OP_LUI, OP_AUIPC,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW,
        OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU,
        OP_DIV, OP_DIVU, OP_REM, OP_REMU
    } op_e;

endpackage

// File: sb_status_if.sv
`timescale 1ns/100ps

interface sb_status_if #(
    parameter int REG_COUNT = 32
);
    import sb_pkg::*;

    logic [NUM_FU-1:0] busy;
    op_e               op [NUM_FU];
    reg_idx_t          dst [NUM_FU];
    reg_idx_t          src1 [NUM_FU];
    reg_idx_t          src2 [NUM_FU];
    fu_e               prod1 [NUM_FU];          // Pending producer of src1.
    fu_e               prod2 [NUM_FU];
    logic [NUM_FU-1:0] rdy1;
    logic [NUM_FU-1:0] rdy2;
    logic [NUM_FU-1:0] done;
    fu_e               reg_status [REG_COUNT];  // Pending writer per register.

    modport tbl (
        output busy, op, dst, src1, src2, prod1, prod2, rdy1, rdy2, done, reg_status
    );

    modport reader (
        input busy, op, dst, src1, src2, prod1, prod2, rdy1, rdy2, done, reg_status
    );

endinterface

// File: issue_unit.sv
`timescale 1ns/100ps

module issue_unit #(
    parameter int REG_COUNT = 32
) (
    input  logic             inst_valid,
    input  logic [31:0]      inst,
    sb_status_if.reader      st,
    output logic             inst_ready,
    output logic             issue_fire,
    output sb_pkg::fu_e      issue_fu,
    output sb_pkg::op_e      issue_op,
    output sb_pkg::reg_idx_t issue_dst,
    output sb_pkg::reg_idx_t issue_src1,
    output sb_pkg::reg_idx_t issue_src2
);
    import sb_pkg::*;

    logic [6:0] funct7;
    logic [2:0] funct3;
    opcode_e    opc;
    fu_e        dec_fu;
    op_e        dec_op;
    logic       use_rd;
    logic       use_rs1;
    logic       use_rs2;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    logic       regs_ok;
    logic       legal;
    logic       unit_busy;
    logic       waw;

    assign funct7 = inst[31:25];
    assign funct3 = inst[14:12];
    assign opc    = opcode_e'(inst[6:0]);

    always_comb begin
        dec_fu  = FU_NONE;
        dec_op  = OP_NONE;
        use_rd  = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        case (opc)
            OPC_OP: begin
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                if (funct7 == 7'h01) begin
                    dec_fu = funct3[2] ? FU_DIV : FU_MUL;
                    case (funct3)
                        3'd0: dec_op = OP_MUL;
                        3'd1: dec_op = OP_MULH;
                        3'd2: dec_op = OP_MULHSU;
                        3'd3: dec_op = OP_MULHU;
                        3'd4: dec_op = OP_DIV;
                        3'd5: dec_op = OP_DIVU;
                        3'd6: dec_op = OP_REM;
                        default: dec_op = OP_REMU;
                    endcase
                end else if (funct7 == 7'h00) begin
                    dec_fu = FU_ALU;
                    case (funct3)
                        3'd0: dec_op = OP_ADD;
                        3'd1: dec_op = OP_SLL;
                        3'd2: dec_op = OP_SLT;
                        3'd3: dec_op = OP_SLTU;
                        3'd4: dec_op = OP_XOR;
                        3'd5: dec_op = OP_SRL;
                        3'd6: dec_op = OP_OR;
                        default: dec_op = OP_AND;
                    endcase
                end else if (funct7 == 7'h20) begin
                    dec_fu = FU_ALU;
                    if (funct3 == 3'd0) dec_op = OP_SUB;
                    if (funct3 == 3'd5) dec_op = OP_SRA;
                end
            end
            OPC_OP_IMM: begin
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
                dec_fu  = FU_ALU;
                case (funct3)
                    3'd0: dec_op = OP_ADDI;
                    3'd2: dec_op = OP_SLTI;
                    3'd3: dec_op = OP_SLTIU;
                    3'd4: dec_op = OP_XORI;
                    3'd6: dec_op = OP_ORI;
                    3'd7: dec_op = OP_ANDI;
                    3'd1: dec_op = (funct7 == 7'h00) ? OP_SLLI : OP_NONE;
                    default: begin
                        if (funct7 == 7'h00) dec_op = OP_SRLI;
                        if (funct7 == 7'h20) dec_op = OP_SRAI;
                    end
                endcase
            end
            OPC_LOAD: begin
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
                dec_fu  = FU_MEM;
                case (funct3)
                    3'd0: dec_op = OP_LB;
                    3'd1: dec_op = OP_LH;
                    3'd2: dec_op = OP_LW;
                    3'd4: dec_op = OP_LBU;
                    3'd5: dec_op = OP_LHU;
                    default: dec_op = OP_NONE;
                endcase
            end
            OPC_STORE: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                dec_fu  = FU_MEM;
                case (funct3)
                    3'd0: dec_op = OP_SB;
                    3'd1: dec_op = OP_SH;
                    3'd2: dec_op = OP_SW;
                    default: dec_op = OP_NONE;
                endcase
            end
            OPC_LUI: begin
                use_rd = 1'b1;
                dec_fu = FU_ALU;
                dec_op = OP_LUI;
            end
            OPC_AUIPC: begin
                use_rd = 1'b1;
                dec_fu = FU_ALU;
                dec_op = OP_AUIPC;
            end
            default: ;
        endcase
        if (dec_op == OP_NONE) dec_fu = FU_NONE;  // Unknown funct field.
    end

    assign rd  = use_rd  ? inst[11:7]  : '0;
    assign rs1 = use_rs1 ? inst[19:15] : '0;
    assign rs2 = use_rs2 ? inst[24:20] : '0;

    // RV32E style parts reject the upper registers.
    assign regs_ok = (int'(rd) < REG_COUNT) && (int'(rs1) < REG_COUNT) &&
                     (int'(rs2) < REG_COUNT);
    assign legal   = (dec_fu != FU_NONE) && regs_ok;

    assign issue_fu   = legal ? dec_fu : FU_NONE;
    assign issue_op   = legal ? dec_op : OP_NONE;
    assign issue_dst  = legal ? rd  : '0;
    assign issue_src1 = legal ? rs1 : '0;
    assign issue_src2 = legal ? rs2 : '0;

    always_comb begin
        unit_busy = 1'b0;
        for (int i = 0; i < NUM_FU; i++) begin
            if (FU_OF_IDX[i] == issue_fu && st.busy[i]) unit_busy = 1'b1;
        end
    end

    assign waw        = (issue_dst != '0) && (st.reg_status[issue_dst] != FU_NONE);
    assign inst_ready = !(unit_busy || waw);
    assign issue_fire = inst_valid && inst_ready;

endmodule

// File: scoreboard_table.sv
`timescale 1ns/100ps

module scoreboard_table #(
    parameter int REG_COUNT = 32
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      issue_fire,
    input  sb_pkg::fu_e               issue_fu,
    input  sb_pkg::op_e               issue_op,
    input  sb_pkg::reg_idx_t          issue_dst,
    input  sb_pkg::reg_idx_t          issue_src1,
    input  sb_pkg::reg_idx_t          issue_src2,
    input  logic                      ro_fire,
    input  sb_pkg::fu_e               ro_fu,
    input  logic [sb_pkg::NUM_FU-1:0] fu_done,
    input  logic                      wb_fire,
    input  sb_pkg::fu_e               wb_fu,
    sb_status_if.tbl                  st
);
    import sb_pkg::*;

    fu_e p1;
    fu_e p2;

    // A producer retiring on the issue edge no longer counts.
    always_comb begin
        p1 = st.reg_status[issue_src1];
        p2 = st.reg_status[issue_src2];
        if (wb_fire && p1 == wb_fu) p1 = FU_NONE;
        if (wb_fire && p2 == wb_fu) p2 = FU_NONE;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_FU; i++) begin
                st.busy[i]  <= 1'b0;
                st.done[i]  <= 1'b0;
                st.rdy1[i]  <= 1'b0;
                st.rdy2[i]  <= 1'b0;
                st.prod1[i] <= FU_NONE;
                st.prod2[i] <= FU_NONE;
            end
            for (int r = 0; r < REG_COUNT; r++) begin
                st.reg_status[r] <= FU_NONE;
            end
        end else begin
            for (int i = 0; i < NUM_FU; i++) begin
                if (fu_done[i]) st.done[i] <= 1'b1;
                if (ro_fire && ro_fu == FU_OF_IDX[i]) begin
                    st.rdy1[i] <= 1'b0;  // Operands consumed.
                    st.rdy2[i] <= 1'b0;
                end
                if (wb_fire && st.prod1[i] == wb_fu) begin
                    st.prod1[i] <= FU_NONE;
                    st.rdy1[i]  <= 1'b1;
                end
                if (wb_fire && st.prod2[i] == wb_fu) begin
                    st.prod2[i] <= FU_NONE;
                    st.rdy2[i]  <= 1'b1;
                end
                if (wb_fire && wb_fu == FU_OF_IDX[i]) begin
                    st.busy[i] <= 1'b0;
                    st.done[i] <= 1'b0;
                    if (st.dst[i] != '0) st.reg_status[st.dst[i]] <= FU_NONE;
                end
                if (issue_fire && issue_fu == FU_OF_IDX[i]) begin
                    st.busy[i]  <= 1'b1;
                    st.done[i]  <= 1'b0;
                    st.prod1[i] <= p1;
                    st.prod2[i] <= p2;
                    st.rdy1[i]  <= (p1 == FU_NONE);
                    st.rdy2[i]  <= (p2 == FU_NONE);
                end
            end
            // Illegal words arrive with a zero destination.
            if (issue_fire && issue_dst != '0) st.reg_status[issue_dst] <= issue_fu;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_FU; i++) begin
            if (issue_fire && issue_fu == FU_OF_IDX[i]) begin
                st.op[i]   <= issue_op;
                st.dst[i]  <= issue_dst;
                st.src1[i] <= issue_src1;
                st.src2[i] <= issue_src2;
            end
        end
    end

endmodule

// File: operand_select.sv
`timescale 1ns/100ps

module operand_select (
    input  logic             clk,
    input  logic             rst,
    sb_status_if.reader      st,
    input  logic             ro_ready,
    output logic             ro_valid,
    output sb_pkg::fu_e      ro_fu,
    output sb_pkg::op_e      ro_op,
    output sb_pkg::reg_idx_t ro_rs1,
    output sb_pkg::reg_idx_t ro_rs2,
    output logic             ro_fire
);
    import sb_pkg::*;

    logic [NUM_FU-1:0] cand;
    logic              any_cand;
    fu_idx_t           pick;
    fu_idx_t           sel;
    logic              lock_valid;
    fu_idx_t           lock_idx;

    // Lowest index wins.
    always_comb begin
        any_cand = 1'b0;
        pick     = '0;
        for (int i = NUM_FU - 1; i >= 0; i--) begin
            cand[i] = st.busy[i] && st.rdy1[i] && st.rdy2[i];
            if (cand[i]) begin
                any_cand = 1'b1;
                pick     = fu_idx_t'(i);
            end
        end
    end

    assign sel      = lock_valid ? lock_idx : pick;  // Held while stalled.
    assign ro_valid = lock_valid || any_cand;
    assign ro_fu    = ro_valid ? FU_OF_IDX[sel] : FU_NONE;
    assign ro_op    = st.op[sel];
    assign ro_rs1   = st.src1[sel];
    assign ro_rs2   = st.src2[sel];
    assign ro_fire  = ro_valid && ro_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lock_valid <= 1'b0;
            lock_idx   <= '0;
        end else begin
            lock_valid <= ro_valid && !ro_ready;
            lock_idx   <= sel;
        end
    end

endmodule

// File: retire_select.sv
`timescale 1ns/100ps

module retire_select (
    input  logic             clk,
    input  logic             rst,
    sb_status_if.reader      st,
    input  logic             wb_ready,
    output logic             wb_valid,
    output sb_pkg::fu_e      wb_fu,
    output sb_pkg::reg_idx_t wb_rd,
    output logic             wb_fire
);
    import sb_pkg::*;

    logic [NUM_FU-1:0] war;
    logic [NUM_FU-1:0] cand;
    logic              any_cand;
    fu_idx_t           pick;
    fu_idx_t           sel;
    logic              lock_valid;
    fu_idx_t           lock_idx;

    // A source still flagged ready has not been read yet.
    always_comb begin
        for (int i = 0; i < NUM_FU; i++) begin
            war[i] = 1'b0;
            for (int j = 0; j < NUM_FU; j++) begin
                if (j != i && st.busy[j] && st.dst[i] != '0 &&
                    ((st.rdy1[j] && st.src1[j] == st.dst[i]) ||
                     (st.rdy2[j] && st.src2[j] == st.dst[i]))) begin
                    war[i] = 1'b1;
                end
            end
        end
    end

    always_comb begin
        any_cand = 1'b0;
        pick     = '0;
        for (int i = NUM_FU - 1; i >= 0; i--) begin
            cand[i] = st.busy[i] && st.done[i] && !war[i];
            if (cand[i]) begin
                any_cand = 1'b1;
                pick     = fu_idx_t'(i);
            end
        end
    end

    assign sel      = lock_valid ? lock_idx : pick;
    assign wb_valid = lock_valid || any_cand;
    assign wb_fu    = wb_valid ? FU_OF_IDX[sel] : FU_NONE;
    assign wb_rd    = st.dst[sel];
    assign wb_fire  = wb_valid && wb_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lock_valid <= 1'b0;
            lock_idx   <= '0;
        end else begin
            lock_valid <= wb_valid && !wb_ready;
            lock_idx   <= sel;
        end
    end

endmodule

// File: scoreboard_top.sv
`timescale 1ns/100ps

module scoreboard_top #(
    parameter int REG_COUNT = 32
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      inst_valid,
    input  logic [31:0]               inst,
    output logic                      inst_ready,
    output logic                      ro_valid,
    output sb_pkg::fu_e               ro_fu,
    output sb_pkg::op_e               ro_op,
    output sb_pkg::reg_idx_t          ro_rs1,
    output sb_pkg::reg_idx_t          ro_rs2,
    input  logic                      ro_ready,
    input  logic [sb_pkg::NUM_FU-1:0] fu_done,
    output logic                      wb_valid,
    output sb_pkg::fu_e               wb_fu,
    output sb_pkg::reg_idx_t          wb_rd,
    input  logic                      wb_ready
);
    import sb_pkg::*;

    logic     issue_fire;
    fu_e      issue_fu;
    op_e      issue_op;
    reg_idx_t issue_dst;
    reg_idx_t issue_src1;
    reg_idx_t issue_src2;
    logic     ro_fire;
    logic     wb_fire;

    sb_status_if #(.REG_COUNT(REG_COUNT)) st_if ();

    issue_unit #(.REG_COUNT(REG_COUNT)) u_issue (
        .inst_valid (inst_valid),
        .inst       (inst),
        .st         (st_if.reader),
        .inst_ready (inst_ready),
        .issue_fire (issue_fire),
        .issue_fu   (issue_fu),
        .issue_op   (issue_op),
        .issue_dst  (issue_dst),
        .issue_src1 (issue_src1),
        .issue_src2 (issue_src2)
    );

    scoreboard_table #(.REG_COUNT(REG_COUNT)) u_table (
        .clk        (clk),
        .rst        (rst),
        .issue_fire (issue_fire),
        .issue_fu   (issue_fu),
        .issue_op   (issue_op),
        .issue_dst  (issue_dst),
        .issue_src1 (issue_src1),
        .issue_src2 (issue_src2),
        .ro_fire    (ro_fire),
        .ro_fu      (ro_fu),
        .fu_done    (fu_done),
        .wb_fire    (wb_fire),
        .wb_fu      (wb_fu),
        .st         (st_if.tbl)
    );

    operand_select u_ro (
        .clk      (clk),
        .rst      (rst),
        .st       (st_if.reader),
        .ro_ready (ro_ready),
        .ro_valid (ro_valid),
        .ro_fu    (ro_fu),
        .ro_op    (ro_op),
        .ro_rs1   (ro_rs1),
        .ro_rs2   (ro_rs2),
        .ro_fire  (ro_fire)
    );

    retire_select u_wb (
        .clk      (clk),
        .rst      (rst),
        .st       (st_if.reader),
        .wb_ready (wb_ready),
        .wb_valid (wb_valid),
        .wb_fu    (wb_fu),
        .wb_rd    (wb_rd),
        .wb_fire  (wb_fire)
    );

endmodule

// File: scoreboard_props.sv
`timescale 1ns/100ps

module scoreboard_props (
    input logic             clk,
    input logic             rst,
    input logic             ro_valid,
    input logic             ro_ready,
    input sb_pkg::fu_e      ro_fu,
    input sb_pkg::op_e      ro_op,
    input sb_pkg::reg_idx_t ro_rs1,
    input sb_pkg::reg_idx_t ro_rs2,
    input logic             wb_valid,
    input logic             wb_ready,
    input sb_pkg::fu_e      wb_fu,
    input sb_pkg::reg_idx_t wb_rd
);

    a_reset_idle: assert property (@(posedge clk) $fell(rst) |-> !ro_valid && !wb_valid)
        else $error("request raised in the first cycle after reset");

    // Stalled requests keep their unit and fields.
    a_ro_hold: assert property (@(posedge clk) disable iff (rst)
        ro_valid && !ro_ready |=> ro_valid && $stable(ro_fu) && $stable(ro_op) &&
                                  $stable(ro_rs1) && $stable(ro_rs2))
        else $error("read-operand request changed while stalled");

    a_wb_hold: assert property (@(posedge clk) disable iff (rst)
        wb_valid && !wb_ready |=> wb_valid && $stable(wb_fu) && $stable(wb_rd))
        else $error("writeback request changed while stalled");

endmodule

bind scoreboard_top scoreboard_props u_props (
    .clk      (clk),
    .rst      (rst),
    .ro_valid (ro_valid),
    .ro_ready (ro_ready),
    .ro_fu    (ro_fu),
    .ro_op    (ro_op),
    .ro_rs1   (ro_rs1),
    .ro_rs2   (ro_rs2),
    .wb_valid (wb_valid),
    .wb_ready (wb_ready),
    .wb_fu    (wb_fu),
    .wb_rd    (wb_rd)
);

// File: tb_scoreboard.sv
`timescale 1ns/100ps

module tb_scoreboard;
    import sb_pkg::*;

    localparam int TMO = 40;

    // Major opcodes from the RV32 base encoding.
    localparam logic [6:0] R_OP   = 7'h33;
    localparam logic [6:0] I_OP   = 7'h13;
    localparam logic [6:0] LD_OP  = 7'h03;
    localparam logic [6:0] ST_OP  = 7'h23;
    localparam logic [6:0] LUI_OP = 7'h37;
    localparam logic [6:0] AUI_OP = 7'h17;
    localparam logic [6:0] JAL_OP = 7'h6f;

    typedef struct packed {
        logic [31:0] word;
        int          ro_stall;   // Negative means random.
        int          wb_stall;
        logic [3:0]  done_mask;
        fu_e         exp_fu;
        op_e         exp_op;
        reg_idx_t    exp_rs1;
        reg_idx_t    exp_rs2;
        reg_idx_t    exp_rd;
    } row_t;

    logic        clk;
    logic        rst;
    logic        inst_valid;
    logic [31:0] inst;
    logic        inst_ready;
    logic        ro_valid;
    fu_e         ro_fu;
    op_e         ro_op;
    reg_idx_t    ro_rs1;
    reg_idx_t    ro_rs2;
    logic        ro_ready;
    logic [3:0]  fu_done;
    logic        wb_valid;
    fu_e         wb_fu;
    reg_idx_t    wb_rd;
    logic        wb_ready;

    row_t rows [$];
    int   errors;
    int   errs_start;
    int   n_pass;
    int   n_fail;

    scoreboard_top #(.REG_COUNT(32)) UUT (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst       (inst),
        .inst_ready (inst_ready),
        .ro_valid   (ro_valid),
        .ro_fu      (ro_fu),
        .ro_op      (ro_op),
        .ro_rs1     (ro_rs1),
        .ro_rs2     (ro_rs2),
        .ro_ready   (ro_ready),
        .fu_done    (fu_done),
        .wb_valid   (wb_valid),
        .wb_fu      (wb_fu),
        .wb_rd      (wb_rd),
        .wb_ready   (wb_ready)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, R_OP};
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], ST_OP};
    endfunction

    function automatic void add_row(logic [31:0] word, int ro_s, int wb_s, logic [3:0] mask,
                                    fu_e fu, op_e op, reg_idx_t rs1, reg_idx_t rs2,
                                    reg_idx_t rd);
        row_t r;
        r.word      = word;
        r.ro_stall  = ro_s;
        r.wb_stall  = wb_s;
        r.done_mask = mask;
        r.exp_fu    = fu;
        r.exp_op    = op;
        r.exp_rs1   = rs1;
        r.exp_rs2   = rs2;
        r.exp_rd    = rd;
        rows.push_back(r);
    endfunction

    function automatic void build_table();
        add_row(enc_r(7'h00, 3, 2, 3'd0, 1), 0, 0, 4'b0001, FU_ALU, OP_ADD, 2, 3, 1);
        add_row(enc_r(7'h20, 6, 5, 3'd0, 4), -1, -1, 4'b0001, FU_ALU, OP_SUB, 5, 6, 4);
        add_row(enc_r(7'h00, 7, 6, 3'd3, 9), 2, 0, 4'b0001, FU_ALU, OP_SLTU, 6, 7, 9);
        add_row(enc_r(7'h00, 2, 1, 3'd6, 0), 0, -1, 4'b0001, FU_ALU, OP_OR, 1, 2, 0);
        add_row(enc_i({7'h20, 5'd3}, 9, 3'd5, 8, I_OP), 0, 3, 4'b0001, FU_ALU, OP_SRAI, 9, 0, 8);
        add_row(enc_i(12'h7ff, 1, 3'd7, 2, I_OP), -1, 0, 4'b0001, FU_ALU, OP_ANDI, 1, 0, 2);
        add_row(enc_i(12'h004, 11, 3'd2, 10, LD_OP), 0, 0, 4'b0010, FU_MEM, OP_LW, 11, 0, 10);
        add_row(enc_i(12'hff0, 13, 3'd4, 14, LD_OP), -1, -1, 4'b0010, FU_MEM, OP_LBU, 13, 0, 14);
        add_row(enc_s(12'h008, 12, 13, 3'd2), 1, 0, 4'b0010, FU_MEM, OP_SW, 13, 12, 0);
        add_row(enc_r(7'h01, 16, 15, 3'd3, 14), 0, 0, 4'b0100, FU_MUL, OP_MULHU, 15, 16, 14);
        add_row(enc_r(7'h01, 2, 1, 3'd1, 31), -1, -1, 4'b0100, FU_MUL, OP_MULH, 1, 2, 31);
        add_row(enc_r(7'h01, 19, 18, 3'd6, 17), 0, 0, 4'b1000, FU_DIV, OP_REM, 18, 19, 17);
        add_row(enc_r(7'h01, 5, 4, 3'd5, 3), -1, -1, 4'b1000, FU_DIV, OP_DIVU, 4, 5, 3);
        add_row({20'h12345, 5'd20, LUI_OP}, 0, 0, 4'b0001, FU_ALU, OP_LUI, 0, 0, 20);
        add_row({20'h00001, 5'd21, AUI_OP}, 1, 1, 4'b0001, FU_ALU, OP_AUIPC, 0, 0, 21);
        add_row({20'h00000, 5'd1, JAL_OP}, 0, 0, 4'b0000, FU_NONE, OP_NONE, 0, 0, 0);
        add_row(enc_i(12'h000, 1, 3'd3, 2, LD_OP), 0, 0, 4'b0000, FU_NONE, OP_NONE, 0, 0, 0);
        add_row(enc_r(7'h20, 2, 1, 3'd1, 3), 0, 0, 4'b0000, FU_NONE, OP_NONE, 0, 0, 0);
    endfunction

    function automatic int stall_of(int s);
        return (s < 0) ? int'($urandom % 4) + 1 : s;
    endfunction

    function automatic void report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
        $display("ERROR %s: got %h, expected %h", name, got, exp);
        errors++;
    endfunction

    function automatic void start_test();
        errs_start = errors;
    endfunction

    function automatic void finish_test(string name);
        if (errors == errs_start) begin
            n_pass++;
            $display("test %-12s ok", name);
        end else begin
            n_fail++;
            $display("test %-12s failed with %0d errors", name, errors - errs_start);
        end
    endfunction

    task automatic issue_inst(input logic [31:0] word);
        int n;
        n          = 0;
        inst       = word;
        inst_valid = 1'b1;
        @(negedge clk);
        while (inst_ready !== 1'b1 && n < TMO) begin
            @(negedge clk);
            n++;
        end
        if (inst_ready !== 1'b1) begin
            $display("Timeout: instruction %h was never accepted", word);
            errors++;
        end
        @(posedge clk);
        #1;
        inst_valid = 1'b0;
    endtask

    task automatic pulse_done(input logic [3:0] mask);
        fu_done = mask;
        @(posedge clk);
        #1;
        fu_done = '0;
    endtask

    // Checks that the selected signals stay low, one sample per cycle.
    task automatic watch_quiet(input int cycles, input bit chk_inst, input bit chk_ro,
                               input bit chk_wb);
        for (int c = 0; c < cycles; c++) begin
            @(negedge clk);
            if (chk_inst && inst_ready !== 1'b0) report_mismatch("inst_ready", 32'(inst_ready), 0);
            if (chk_ro && ro_valid !== 1'b0) report_mismatch("ro_valid", 32'(ro_valid), 0);
            if (chk_wb && wb_valid !== 1'b0) report_mismatch("wb_valid", 32'(wb_valid), 0);
            @(posedge clk);
            #1;
        end
    endtask

    task automatic expect_ro(input int stall, input fu_e efu, input op_e eop,
                             input reg_idx_t e1, input reg_idx_t e2);
        int n;
        n        = 0;
        ro_ready = (stall == 0);
        @(negedge clk);
        while (ro_valid !== 1'b1 && n < TMO) begin
            @(negedge clk);
            n++;
        end
        if (ro_valid !== 1'b1) begin
            $display("Timeout: no operand read request for unit %s", efu.name());
            errors++;
        end else begin
            if (stall > 0) begin
                repeat (stall) @(posedge clk);
                #1;
                ro_ready = 1'b1;
                @(negedge clk);
                if (ro_valid !== 1'b1) begin
                    $display("Operand read request dropped before its transfer");
                    errors++;
                end
            end
            if (ro_fu !== efu) report_mismatch("ro_fu", 32'(ro_fu), 32'(efu));
            if (ro_op !== eop) report_mismatch("ro_op", 32'(ro_op), 32'(eop));
            if (ro_rs1 !== e1) report_mismatch("ro_rs1", 32'(ro_rs1), 32'(e1));
            if (ro_rs2 !== e2) report_mismatch("ro_rs2", 32'(ro_rs2), 32'(e2));
        end
        @(posedge clk);
        #1;
        ro_ready = 1'b0;
    endtask

    task automatic expect_wb(input int stall, input fu_e efu, input reg_idx_t erd);
        int n;
        n        = 0;
        wb_ready = (stall == 0);
        @(negedge clk);
        while (wb_valid !== 1'b1 && n < TMO) begin
            @(negedge clk);
            n++;
        end
        if (wb_valid !== 1'b1) begin
            $display("Timeout: no writeback request for unit %s", efu.name());
            errors++;
        end else begin
            if (stall > 0) begin
                repeat (stall) @(posedge clk);
                #1;
                wb_ready = 1'b1;
                @(negedge clk);
                if (wb_valid !== 1'b1) begin
                    $display("Writeback request dropped before its transfer");
                    errors++;
                end
            end
            if (wb_fu !== efu) report_mismatch("wb_fu", 32'(wb_fu), 32'(efu));
            if (wb_rd !== erd) report_mismatch("wb_rd", 32'(wb_rd), 32'(erd));
        end
        @(posedge clk);
        #1;
        wb_ready = 1'b0;
    endtask

    initial begin
        void'($urandom(72896));
        clk        = 1'b0;
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        ro_ready   = 1'b0;
        fu_done    = '0;
        wb_ready   = 1'b0;
        errors     = 0;
        errs_start = 0;
        n_pass     = 0;
        n_fail     = 0;
        build_table();
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        start_test();
        inst = enc_r(7'h00, 3, 2, 3'd0, 1);  // Legal word, so ready reflects the table.
        @(negedge clk);
        if (inst_ready !== 1'b1) report_mismatch("inst_ready", 32'(inst_ready), 1);
        if (ro_valid !== 1'b0) report_mismatch("ro_valid", 32'(ro_valid), 0);
        if (wb_valid !== 1'b0) report_mismatch("wb_valid", 32'(wb_valid), 0);
        @(posedge clk);
        #1;
        finish_test("reset");

        for (int i = 0; i < rows.size(); i++) begin
            start_test();
            issue_inst(rows[i].word);
            if (rows[i].exp_fu == FU_NONE) begin
                watch_quiet(4, 1'b0, 1'b1, 1'b1);  // Illegal word leaves no trace.
            end else begin
                expect_ro(stall_of(rows[i].ro_stall), rows[i].exp_fu, rows[i].exp_op,
                          rows[i].exp_rs1, rows[i].exp_rs2);
                pulse_done(rows[i].done_mask);
                expect_wb(stall_of(rows[i].wb_stall), rows[i].exp_fu, rows[i].exp_rd);
                watch_quiet(1, 1'b0, 1'b1, 1'b1);
            end
            finish_test($sformatf("decode_%0d", i));
        end

        start_test();
        issue_inst(enc_r(7'h01, 3, 2, 3'd0, 1));
        inst       = enc_r(7'h01, 6, 5, 3'd0, 4);  // Second MUL waits on the busy unit.
        inst_valid = 1'b1;
        watch_quiet(2, 1'b1, 1'b0, 1'b0);
        expect_ro(0, FU_MUL, OP_MUL, 2, 3);
        watch_quiet(1, 1'b1, 1'b0, 1'b0);
        pulse_done(4'b0100);
        expect_wb(0, FU_MUL, 1);
        issue_inst(enc_r(7'h01, 6, 5, 3'd0, 4));
        expect_ro(0, FU_MUL, OP_MUL, 5, 6);
        pulse_done(4'b0100);
        expect_wb(0, FU_MUL, 4);
        watch_quiet(1, 1'b0, 1'b1, 1'b1);
        finish_test("structural");

        start_test();
        issue_inst(enc_i(12'h000, 1, 3'd2, 5, LD_OP));
        inst       = enc_r(7'h00, 3, 2, 3'd0, 5);
        inst_valid = 1'b1;
        watch_quiet(3, 1'b1, 1'b0, 1'b0);
        expect_ro(0, FU_MEM, OP_LW, 1, 0);
        pulse_done(4'b0010);
        watch_quiet(1, 1'b1, 1'b0, 1'b0);
        expect_wb(0, FU_MEM, 5);
        issue_inst(enc_r(7'h00, 3, 2, 3'd0, 5));
        expect_ro(0, FU_ALU, OP_ADD, 2, 3);
        pulse_done(4'b0001);
        expect_wb(0, FU_ALU, 5);
        watch_quiet(1, 1'b0, 1'b1, 1'b1);
        finish_test("waw");

        start_test();
        issue_inst(enc_r(7'h01, 2, 1, 3'd0, 7));
        expect_ro(0, FU_MUL, OP_MUL, 1, 2);
        issue_inst(enc_r(7'h00, 4, 7, 3'd0, 8));
        watch_quiet(3, 1'b0, 1'b1, 1'b0);
        pulse_done(4'b0100);
        expect_wb(0, FU_MUL, 7);
        expect_ro(0, FU_ALU, OP_ADD, 7, 4);
        pulse_done(4'b0001);
        expect_wb(0, FU_ALU, 8);
        watch_quiet(1, 1'b0, 1'b1, 1'b1);
        finish_test("raw");

        start_test();
        issue_inst(enc_i(12'h000, 1, 3'd2, 9, LD_OP));
        expect_ro(0, FU_MEM, OP_LW, 1, 0);
        issue_inst(enc_r(7'h01, 1, 9, 3'd4, 10));
        issue_inst(enc_r(7'h01, 2, 9, 3'd0, 11));
        issue_inst(enc_r(7'h00, 3, 9, 3'd0, 12));
        watch_quiet(2, 1'b0, 1'b1, 1'b0);
        pulse_done(4'b0010);
        expect_wb(0, FU_MEM, 9);
        expect_ro(0, FU_ALU, OP_ADD, 9, 3);  // All three wake on the same edge.
        expect_ro(0, FU_MUL, OP_MUL, 9, 2);
        expect_ro(0, FU_DIV, OP_DIV, 9, 1);
        pulse_done(4'b1101);
        expect_wb(0, FU_ALU, 12);
        expect_wb(0, FU_MUL, 11);
        expect_wb(0, FU_DIV, 10);
        watch_quiet(1, 1'b0, 1'b1, 1'b1);
        finish_test("priority");

        start_test();
        issue_inst(enc_r(7'h01, 4, 3, 3'd4, 13));
        issue_inst(enc_r(7'h00, 2, 1, 3'd0, 3));
        pulse_done(4'b0001);
        watch_quiet(3, 1'b0, 1'b0, 1'b1);  // DIV has not read x3 yet.
        expect_ro(0, FU_DIV, OP_DIV, 3, 4);
        expect_ro(0, FU_ALU, OP_ADD, 1, 2);
        expect_wb(0, FU_ALU, 3);
        pulse_done(4'b1000);
        expect_wb(0, FU_DIV, 13);
        watch_quiet(1, 1'b0, 1'b1, 1'b1);
        finish_test("war");

        start_test();
        issue_inst(enc_r(7'h00, 2, 1, 3'd0, 20));
        issue_inst(enc_i(12'h010, 3, 3'd2, 21, LD_OP));
        issue_inst(enc_r(7'h01, 5, 4, 3'd0, 22));
        issue_inst(enc_r(7'h01, 7, 6, 3'd4, 23));
        expect_ro(stall_of(-1), FU_ALU, OP_ADD, 1, 2);
        expect_ro(stall_of(-1), FU_MEM, OP_LW, 3, 0);
        expect_ro(stall_of(-1), FU_MUL, OP_MUL, 4, 5);
        expect_ro(stall_of(-1), FU_DIV, OP_DIV, 6, 7);
        pulse_done(4'b1111);
        expect_wb(stall_of(-1), FU_ALU, 20);
        expect_wb(stall_of(-1), FU_MEM, 21);
        expect_wb(stall_of(-1), FU_MUL, 22);
        expect_wb(stall_of(-1), FU_DIV, 23);
        watch_quiet(2, 1'b0, 1'b1, 1'b1);
        finish_test("burst");

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 n_pass + n_fail, n_pass, n_fail, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: filelist.f
sb_pkg.sv
sb_status_if.sv
issue_unit.sv
scoreboard_table.sv
operand_select.sv
retire_select.sv
scoreboard_top.sv
scoreboard_props.sv
tb_scoreboard.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert --timescale 1ns/100ps --top-module tb_scoreboard \
    -f filelist.f -o tb_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q '\*\*\* FAILED \*\*\*' sim.log && exit 1 || exit 0
